// File: keyexp.f
+incdir+verilog
verilog/keyexp_pkg.sv
verilog/aes_sbox.sv
verilog/key_schedule_ctrl.sv
verilog/round_key_store.sv
verilog/keyexp_apb_regs.sv
verilog/keyexp_top.sv
test/keyexp_tb_sva.sv
test/keyexp_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= keyexp_tb
FILELIST  ?= keyexp.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
# keep running after an assertion error so the testbench reaches its summary
SIM_ARGS  ?= +verilator+error+limit+100000
PASS_MSG  ?= ** PASS **

SOURCES := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: test/keyexp_tb.sv
`timescale 1ns/1ps
`include "keyexp_macros.svh"

module keyexp_tb;

   import keyexp_pkg::*;

   // nine expansions of about 150 cycles each, doubled
   localparam int TIMEOUT_CYCLES = 3000;
   localparam int BUSY_CYCLES    = 41;

   logic     i_clk;
   logic     i_reset;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;
   int       cycle;
   int       start_cycle;
   int       errors;
   int       tests_run;
   int       tests_failed;
   // expected expanded key from the model
   word_t    exp_w [`KE_WORDS];

   keyexp_top u_dut (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_apb   (apb_req),
      .o_apb   (apb_rsp)
   );

   always #10 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         $display("** FAIL **");
         $finish;
      end
   end

   function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] p;
      logic [7:0] x;
      p = 8'h00;
      x = a;
      for (int k = 0; k < 8; k++) begin
         if (b[k]) begin
            p = p ^ x;
         end
         x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
      end
      return p;
   endfunction

   // b^254 is the field inverse and maps 0 to 0, then the affine map
   function automatic logic [7:0] sbox_model(input logic [7:0] b);
      logic [7:0] inv;
      inv = 8'h01;
      for (int k = 0; k < 254; k++) begin
         inv = gf_mul(inv, b);
      end
      return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]} ^
             {inv[3:0], inv[7:4]} ^ 8'h63;
   endfunction

   task automatic expand_model(input key_t key);
      word_t      t;
      logic [7:0] rc;
      rc = 8'h01;
      for (int i = 0; i < `KE_NK; i++) begin
         exp_w[i] = key[i];
      end
      for (int i = `KE_NK; i < `KE_WORDS; i++) begin
         t = exp_w[i-1];
         if (i % `KE_NK == 0) begin
            t = {t[23:0], t[31:24]};
            for (int j = 0; j < 4; j++) begin
               t[8*j +: 8] = sbox_model(t[8*j +: 8]);
            end
            t[31:24] = t[31:24] ^ rc;
            rc = gf_mul(rc, 8'h02);
         end
         exp_w[i] = exp_w[i-`KE_NK] ^ t;
      end
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         errors++;
         $display("Error at %0d ns: %s read %08h, expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic check_rsp(input string what, input apb_rsp_t got, input logic exp_err);
      if (got.pslverr !== exp_err) begin
         errors++;
         $display("Error at %0d ns: %s slave error %0b, expected %0b",
                  $time, what, got.pslverr, exp_err);
      end
   endtask

   task automatic apb_xfer(input logic write, input logic [`KE_ADDR_W-1:0] addr,
                           input word_t wdata, input logic exp_err, output apb_rsp_t rsp);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge i_clk);
      #1;
      apb_req.penable = 1'b1;
      // response settles well before the falling edge
      @(negedge i_clk);
      while (!apb_rsp.pready) begin
         @(negedge i_clk);
      end
      rsp = apb_rsp;
      check_rsp($sformatf("%s %03h", write ? "write" : "read", addr), rsp, exp_err);
      @(posedge i_clk);
      #1;
      apb_req = '0;
   endtask

   task automatic apb_write(input logic [`KE_ADDR_W-1:0] addr, input word_t data,
                            input logic exp_err);
      apb_rsp_t rsp;
      apb_xfer(1'b1, addr, data, exp_err, rsp);
   endtask

   task automatic apb_read(input logic [`KE_ADDR_W-1:0] addr, input logic exp_err,
                           output word_t data);
      apb_rsp_t rsp;
      apb_xfer(1'b0, addr, '0, exp_err, rsp);
      data = rsp.prdata;
   endtask

   task automatic load_key(input key_t key);
      for (int j = 0; j < `KE_NK; j++) begin
         apb_write(`KE_ADDR_KEY + 12'(4 * j), key[j], 1'b0);
      end
   endtask

   task automatic start_expansion();
      apb_write(`KE_ADDR_CTRL, 32'h1, 1'b0);
      start_cycle = cycle;
   endtask

   // elapsed counts from the start edge to the cycle the status was sampled
   task automatic wait_done(output int elapsed);
      word_t status;
      status  = '0;
      elapsed = 0;
      while (!status[1]) begin
         apb_read(`KE_ADDR_STATUS, 1'b0, status);
         elapsed = cycle - 1 - start_cycle;
         if (status[0] && elapsed >= BUSY_CYCLES) begin
            errors++;
            $display("Error at %0d ns: still busy %0d cycles after start", $time, elapsed);
         end
      end
   endtask

   task automatic check_expansion(input key_t key);
      word_t data;
      expand_model(key);
      for (int i = 0; i < `KE_WORDS; i++) begin
         apb_read(`KE_ADDR_RKEY + 12'(4 * i), 1'b0, data);
         check_word($sformatf("round key word %0d", i), data, exp_w[i]);
      end
   endtask

   task automatic run_key(input key_t key);
      int elapsed;
      load_key(key);
      start_expansion();
      wait_done(elapsed);
      check_expansion(key);
   endtask

   task automatic end_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic test_fips_key();
      key_t  key;
      word_t data;
      int    e0;
      e0     = errors;
      key[0] = 32'h2b7e1516;
      key[1] = 32'h28aed2a6;
      key[2] = 32'habf71588;
      key[3] = 32'h09cf4f3c;
      run_key(key);
      // last word of the FIPS-197 worked example
      apb_read(`KE_ADDR_RKEY + 12'(4 * 43), 1'b0, data);
      check_word("word 43 of the FIPS-197 key", data, 32'hb6630ca6);
      end_test("fips_key", e0);
   endtask

   task automatic test_random_keys();
      key_t key;
      int   e0;
      e0 = errors;
      for (int n = 0; n < 5; n++) begin
         for (int j = 0; j < `KE_NK; j++) begin
            key[j] = $urandom();
         end
         run_key(key);
      end
      end_test("random_keys", e0);
   endtask

   task automatic test_busy_status();
      key_t  key;
      word_t status;
      int    elapsed;
      int    e0;
      e0 = errors;
      for (int j = 0; j < `KE_NK; j++) begin
         key[j] = $urandom();
      end
      load_key(key);
      start_expansion();
      apb_read(`KE_ADDR_STATUS, 1'b0, status);
      check_word("status right after start", status, 32'h1);
      wait_done(elapsed);
      if (elapsed < BUSY_CYCLES || elapsed > BUSY_CYCLES + 1) begin
         errors++;
         $display("Error at %0d ns: done seen %0d cycles after start", $time, elapsed);
      end
      end_test("busy_status", e0);
   endtask

   task automatic test_busy_errors();
      key_t  key;
      word_t data;
      int    elapsed;
      int    e0;
      e0     = errors;
      key[0] = 32'h00010203;
      key[1] = 32'h04050607;
      key[2] = 32'h08090a0b;
      key[3] = 32'h0c0d0e0f;
      load_key(key);
      start_expansion();
      apb_read(`KE_ADDR_RKEY + 12'(4 * 8), 1'b1, data);
      apb_write(`KE_ADDR_KEY, 32'hdeadbeef, 1'b1);
      apb_write(`KE_ADDR_CTRL, 32'h1, 1'b1);
      wait_done(elapsed);
      for (int j = 0; j < `KE_NK; j++) begin
         apb_read(`KE_ADDR_KEY + 12'(4 * j), 1'b0, data);
         check_word($sformatf("key register %0d", j), data, key[j]);
      end
      check_expansion(key);
      end_test("busy_errors", e0);
   endtask

   task automatic test_unmapped_restart();
      key_t  key;
      word_t data;
      int    e0;
      e0 = errors;
      apb_read(12'h020, 1'b1, data);
      apb_read(12'h1b0, 1'b1, data);
      apb_write(12'h018, 32'h1, 1'b1);
      for (int j = 0; j < `KE_NK; j++) begin
         key[j] = $urandom();
      end
      // scheduler sits in DONE here, so this restarts it
      run_key(key);
      end_test("unmapped_restart", e0);
   endtask

   initial begin
      i_clk        = 1'b0;
      i_reset      = 1'b1;
      apb_req      = '0;
      start_cycle  = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(56909));
      repeat (10) @(posedge i_clk);
      #1;
      i_reset = 1'b0;
      test_fips_key();
      test_random_keys();
      test_busy_status();
      test_busy_errors();
      test_unmapped_restart();
      $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
               tests_run, tests_failed, errors, u_dut.u_sva.fail_count);
      if (errors == 0 && u_dut.u_sva.fail_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: test/keyexp_tb_sva.sv
`timescale 1ns/1ps
`include "keyexp_macros.svh"

module keyexp_tb_sva (
   input logic                    i_clk,
   input logic                    i_reset,
   input keyexp_pkg::apb_rsp_t    i_apb_rsp,
   input logic                    i_busy,
   input logic                    i_done,
   input logic                    i_start,
   input logic [`KE_IDX_W-1:0]    i_fill
);

   // LOAD plus 40 EXPAND cycles
   localparam int BUSY_CYCLES = 41;

   int fail_count = 0;

   a_ready: assert property (@(posedge i_clk) disable iff (i_reset) i_apb_rsp.pready)
      else begin
         fail_count++;
         $error("pready dropped low");
      end

   a_busy_done: assert property (@(posedge i_clk) disable iff (i_reset) !(i_busy && i_done))
      else begin
         fail_count++;
         $error("busy and done both high");
      end

   // busy rises on the edge after start and falls BUSY_CYCLES later
   a_busy_len: assert property (@(posedge i_clk) disable iff (i_reset)
      i_start |-> ##1 i_busy ##BUSY_CYCLES $fell(i_busy))
      else begin
         fail_count++;
         $error("busy did not fall %0d cycles after start", BUSY_CYCLES);
      end

   // the store's fill level only moves on edges where the scheduler is busy
   a_idle_write: assert property (@(posedge i_clk) disable iff (i_reset)
      !i_busy |=> $stable(i_fill))
      else begin
         fail_count++;
         $error("store written while the scheduler is idle");
      end

endmodule

bind keyexp_top keyexp_tb_sva u_sva (
   .i_clk     (i_clk),
   .i_reset   (i_reset),
   .i_apb_rsp (o_apb),
   .i_busy    (busy),
   .i_done    (done),
   .i_start   (start),
   .i_fill    (u_store.fill_q)
);

// File: verilog/keyexp_top.sv
`timescale 1ns/1ps
`include "keyexp_macros.svh"

module keyexp_top (
   input  logic                 i_clk,
   input  logic                 i_reset,
   input  keyexp_pkg::apb_req_t i_apb,
   output keyexp_pkg::apb_rsp_t o_apb
);

   import keyexp_pkg::*;

   logic                 start;
   logic                 busy;
   logic                 done;
   key_t                 key;
   store_load_t          load;
   sched_req_t           req;
   word_t                last_word;
   word_t                sub_word;
   word_t                rd_word;
   logic [`KE_IDX_W-1:0] rd_idx;

   keyexp_apb_regs u_regs (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_apb     (i_apb),
      .o_apb     (o_apb),
      .i_busy    (busy),
      .i_done    (done),
      .o_start   (start),
      .o_key     (key),
      .o_rd_idx  (rd_idx),
      .i_rd_word (rd_word)
   );

   key_schedule_ctrl u_ctrl (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_start     (start),
      .i_key       (key),
      .i_last_word (last_word),
      .o_load      (load),
      .o_req       (req),
      .o_busy      (busy),
      .o_done      (done)
   );

   // SubWord, one lane per byte of the rotated word
   for (genvar g = 0; g < `KE_WORD_W / 8; g++) begin : g_lane
      aes_sbox u_sbox (
         .i_byte (req.rot_word[8*g +: 8]),
         .o_byte (sub_word[8*g +: 8])
      );
   end

   round_key_store u_store (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_load      (load),
      .i_req       (req),
      .i_sub_word  (sub_word),
      .o_last_word (last_word),
      .i_rd_idx    (rd_idx),
      .o_rd_word   (rd_word)
   );

endmodule

// File: verilog/keyexp_apb_regs.sv
`timescale 1ns/1ps
`include "keyexp_macros.svh"

module keyexp_apb_regs (
   input  logic                     i_clk,
   input  logic                     i_reset,
   input  keyexp_pkg::apb_req_t     i_apb,
   output keyexp_pkg::apb_rsp_t     o_apb,
   input  logic                     i_busy,
   input  logic                     i_done,
   output logic                     o_start,
   output keyexp_pkg::key_t         o_key,
   output logic [`KE_IDX_W-1:0]     o_rd_idx,
   input  keyexp_pkg::word_t        i_rd_word
);

   import keyexp_pkg::*;

   localparam int KEY_SEL_W = $clog2(`KE_NK);

   key_t                  key_q;
   logic                  access;
   logic [`KE_ADDR_W-1:0] key_off;
   logic [`KE_ADDR_W-1:0] rkey_off;
   logic [KEY_SEL_W-1:0]  key_sel;
   logic                  key_hit;
   logic                  ctrl_hit;
   logic                  status_hit;
   logic                  rkey_hit;
   logic                  mapped;
   logic                  busy_err;
   logic                  err;
   logic                  wr_en;
   word_t                 rdata;

   // no wait states, every access phase completes
   assign access = i_apb.psel & i_apb.penable;

   // offsets wrap below the base, so one compare covers both ends
   assign key_off  = i_apb.paddr - `KE_ADDR_KEY;
   assign rkey_off = i_apb.paddr - `KE_ADDR_RKEY;
   assign key_sel  = key_off[KEY_SEL_W+1:2];
   assign o_rd_idx = rkey_off[`KE_IDX_W+1:2];

   assign key_hit    = (key_off < `KE_ADDR_W'(4 * `KE_NK)) && (key_off[1:0] == 2'b00);
   assign rkey_hit   = (rkey_off < `KE_ADDR_W'(4 * `KE_WORDS)) && (rkey_off[1:0] == 2'b00);
   assign ctrl_hit   = (i_apb.paddr == `KE_ADDR_CTRL);
   assign status_hit = (i_apb.paddr == `KE_ADDR_STATUS);
   assign mapped     = key_hit | ctrl_hit | status_hit | rkey_hit;

   // key and control are locked and the store is half built while busy
   assign busy_err = i_busy & ((i_apb.pwrite & (key_hit | ctrl_hit)) |
                               (!i_apb.pwrite & rkey_hit));
   assign err      = access & (!mapped | busy_err);
   assign wr_en    = access & i_apb.pwrite & !err;

   // start is bit 0 of control, self-clearing
   assign o_start = wr_en & ctrl_hit & i_apb.pwdata[0];

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         key_q <= '0;
      end else if (wr_en && key_hit) begin
         key_q[key_sel] <= i_apb.pwdata;
      end
   end

   always_comb begin
      rdata = '0;
      if (access && !i_apb.pwrite && !err) begin
         if (key_hit) begin
            rdata = key_q[key_sel];
         end else if (status_hit) begin
            // bit 0 busy, bit 1 done
            rdata = {{(`KE_WORD_W-2){1'b0}}, i_done, i_busy};
         end else if (rkey_hit) begin
            rdata = i_rd_word;
         end
      end
   end

   always_comb begin
      o_apb.prdata  = rdata;
      o_apb.pready  = 1'b1;
      o_apb.pslverr = err;
   end

   assign o_key = key_q;

endmodule

// File: verilog/round_key_store.sv
`timescale 1ns/1ps
`include "keyexp_macros.svh"

module round_key_store (
   input  logic                    i_clk,
   input  logic                    i_reset,
   input  keyexp_pkg::store_load_t i_load,
   input  keyexp_pkg::sched_req_t  i_req,
   input  keyexp_pkg::word_t       i_sub_word,
   output keyexp_pkg::word_t       o_last_word,
   input  logic [`KE_IDX_W-1:0]    i_rd_idx,
   output keyexp_pkg::word_t       o_rd_word
);

   import keyexp_pkg::*;

   word_t                mem [`KE_WORDS];
   word_t                last_q;
   word_t                back_word;
   word_t                new_word;
   // number of valid words, reads above it return zero
   logic [`KE_IDX_W-1:0] fill_q;

   // w[i-4]
   assign back_word = mem[i_req.idx - `KE_IDX_W'(`KE_NK)];

   always_comb begin
      if (i_req.sub_word) begin
         new_word = i_sub_word ^ {i_req.rcon, {(`KE_WORD_W-8){1'b0}}} ^ back_word;
      end else begin
         new_word = last_q ^ back_word;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_load.valid) begin
         for (int k = 0; k < `KE_NK; k++) begin
            mem[k] <= i_load.key[k];
         end
         last_q <= i_load.key[`KE_NK-1];
      end else if (i_req.valid) begin
         mem[i_req.idx] <= new_word;
         last_q         <= new_word;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         fill_q <= '0;
      end else if (i_load.valid) begin
         fill_q <= `KE_IDX_W'(`KE_NK);
      end else if (i_req.valid) begin
         fill_q <= i_req.idx + 1'b1;
      end
   end

   assign o_last_word = last_q;
   assign o_rd_word   = (i_rd_idx < fill_q) ? mem[i_rd_idx] : '0;

endmodule

// File: verilog/key_schedule_ctrl.sv
`timescale 1ns/1ps
`include "keyexp_macros.svh"

module key_schedule_ctrl (
   input  logic                    i_clk,
   input  logic                    i_reset,
   input  logic                    i_start,
   input  keyexp_pkg::key_t        i_key,
   input  keyexp_pkg::word_t       i_last_word,
   output keyexp_pkg::store_load_t o_load,
   output keyexp_pkg::sched_req_t  o_req,
   output logic                    o_busy,
   output logic                    o_done
);

   import keyexp_pkg::*;

   // index of word 43, the last one built
   localparam int LAST_IDX = `KE_NK * (`KE_NR + 1) - 1;

   sched_state_t         state_q;
   logic [`KE_IDX_W-1:0] idx_q;
   logic [7:0]           rcon_q;
   logic                 sub_word;

   // multiply by x in GF(2^8), reduction polynomial 0x11b
   function automatic logic [7:0] xtime(input logic [7:0] b);
      return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
   endfunction

   // first word of each group of four takes the rot/sub/rcon path
   assign sub_word = (idx_q[1:0] == 2'b00);

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state_q <= IDLE;
         idx_q   <= '0;
         rcon_q  <= 8'h01;
      end else begin
         case (state_q)
            IDLE, DONE: begin
               if (i_start) begin
                  state_q <= LOAD;
                  idx_q   <= `KE_IDX_W'(`KE_NK);
                  rcon_q  <= 8'h01;
               end
            end
            LOAD: begin
               state_q <= EXPAND;
            end
            EXPAND: begin
               idx_q <= idx_q + 1'b1;
               // constant moves on once a group has used it
               if (sub_word) begin
                  rcon_q <= xtime(rcon_q);
               end
               if (idx_q == `KE_IDX_W'(LAST_IDX)) begin
                  state_q <= DONE;
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   always_comb begin
      o_load.valid   = (state_q == LOAD);
      o_load.key     = i_key;
      o_req.idx      = idx_q;
      o_req.valid    = (state_q == EXPAND);
      o_req.sub_word = sub_word;
      // RotWord, top byte wraps to the bottom
      o_req.rot_word = {i_last_word[23:0], i_last_word[31:24]};
      o_req.rcon     = rcon_q;
   end

   assign o_busy = (state_q == LOAD) || (state_q == EXPAND);
   assign o_done = (state_q == DONE);

endmodule

// File: verilog/aes_sbox.sv
`timescale 1ns/1ps

module aes_sbox (
   input  logic [7:0] i_byte,
   output logic [7:0] o_byte
);

   // forward S-box, row = high nibble, column = low nibble
   localparam logic [7:0] SBOX [256] = '{
      'h63, 'h7c, 'h77, 'h7b, 'hf2, 'h6b, 'h6f, 'hc5, 'h30, 'h01, 'h67, 'h2b, 'hfe, 'hd7, 'hab, 'h76,
      'hca, 'h82, 'hc9, 'h7d, 'hfa, 'h59, 'h47, 'hf0, 'had, 'hd4, 'ha2, 'haf, 'h9c, 'ha4, 'h72, 'hc0,
      'hb7, 'hfd, 'h93, 'h26, 'h36, 'h3f, 'hf7, 'hcc, 'h34, 'ha5, 'he5, 'hf1, 'h71, 'hd8, 'h31, 'h15,
      'h04, 'hc7, 'h23, 'hc3, 'h18, 'h96, 'h05, 'h9a, 'h07, 'h12, 'h80, 'he2, 'heb, 'h27, 'hb2, 'h75,
      'h09, 'h83, 'h2c, 'h1a, 'h1b, 'h6e, 'h5a, 'ha0, 'h52, 'h3b, 'hd6, 'hb3, 'h29, 'he3, 'h2f, 'h84,
      'h53, 'hd1, 'h00, 'hed, 'h20, 'hfc, 'hb1, 'h5b, 'h6a, 'hcb, 'hbe, 'h39, 'h4a, 'h4c, 'h58, 'hcf,
      'hd0, 'hef, 'haa, 'hfb, 'h43, 'h4d, 'h33, 'h85, 'h45, 'hf9, 'h02, 'h7f, 'h50, 'h3c, 'h9f, 'ha8,
      'h51, 'ha3, 'h40, 'h8f, 'h92, 'h9d, 'h38, 'hf5, 'hbc, 'hb6, 'hda, 'h21, 'h10, 'hff, 'hf3, 'hd2,
      'hcd, 'h0c, 'h13, 'hec, 'h5f, 'h97, 'h44, 'h17, 'hc4, 'ha7, 'h7e, 'h3d, 'h64, 'h5d, 'h19, 'h73,
      'h60, 'h81, 'h4f, 'hdc, 'h22, 'h2a, 'h90, 'h88, 'h46, 'hee, 'hb8, 'h14, 'hde, 'h5e, 'h0b, 'hdb,
      'he0, 'h32, 'h3a, 'h0a, 'h49, 'h06, 'h24, 'h5c, 'hc2, 'hd3, 'hac, 'h62, 'h91, 'h95, 'he4, 'h79,
      'he7, 'hc8, 'h37, 'h6d, 'h8d, 'hd5, 'h4e, 'ha9, 'h6c, 'h56, 'hf4, 'hea, 'h65, 'h7a, 'hae, 'h08,
      'hba, 'h78, 'h25, 'h2e, 'h1c, 'ha6, 'hb4, 'hc6, 'he8, 'hdd, 'h74, 'h1f, 'h4b, 'hbd, 'h8b, 'h8a,
      'h70, 'h3e, 'hb5, 'h66, 'h48, 'h03, 'hf6, 'h0e, 'h61, 'h35, 'h57, 'hb9, 'h86, 'hc1, 'h1d, 'h9e,
      'he1, 'hf8, 'h98, 'h11, 'h69, 'hd9, 'h8e, 'h94, 'h9b, 'h1e, 'h87, 'he9, 'hce, 'h55, 'h28, 'hdf,
      'h8c, 'ha1, 'h89, 'h0d, 'hbf, 'he6, 'h42, 'h68, 'h41, 'h99, 'h2d, 'h0f, 'hb0, 'h54, 'hbb, 'h16
   };

   assign o_byte = SBOX[i_byte];

endmodule

// File: verilog/keyexp_pkg.sv
`include "keyexp_macros.svh"

package keyexp_pkg;

   typedef logic [`KE_WORD_W-1:0] word_t;

   // word 0 of the key sits at index 0
   typedef word_t [`KE_NK-1:0] key_t;

   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      EXPAND,
      DONE
   } sched_state_t;

   // one new expanded-key word per valid cycle
   typedef struct packed {
      logic [`KE_IDX_W-1:0] idx;
      logic                 valid;
      logic                 sub_word;
      word_t                rot_word;
      logic [7:0]           rcon;
   } sched_req_t;

   typedef struct packed {
      logic valid;
      key_t key;
   } store_load_t;

   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [`KE_ADDR_W-1:0] paddr;
      word_t                 pwdata;
   } apb_req_t;

   typedef struct packed {
      word_t prdata;
      logic  pready;
      logic  pslverr;
   } apb_rsp_t;

endpackage

// File: verilog/keyexp_macros.svh
`ifndef KEYEXP_MACROS_SVH
`define KEYEXP_MACROS_SVH

// AES-128 key geometry
`define KE_NK      4
`define KE_NR      10
`define KE_WORDS   44
`define KE_WORD_W  32
`define KE_IDX_W   6

// APB register map, byte offsets
`define KE_ADDR_W      12
`define KE_ADDR_KEY    12'h000
`define KE_ADDR_CTRL   12'h010
`define KE_ADDR_STATUS 12'h014
`define KE_ADDR_RKEY   12'h100

`endif
